/* hdl/mioc_bus_pkg.sv */
// z80 bus types
`default_nettype none

package mioc_bus_pkg;

   // address lines that reach the chip, msb first
   typedef struct packed {
      logic a15;   // selects lower or upper 32k half
      logic a14;
      logic a13;
      logic a7;    // row bit of ra7, port select msb
      logic a6;    // port select lsb
   } z80_addr_t;

   // buffered z80 strobes, all active low
   typedef struct packed {
      logic mreq_n;   // memory request
      logic iorq_n;   // i/o request
      logic rd_n;     // read strobe
      logic wr_n;     // write strobe
      logic rfsh_n;   // refresh phase of m1
   } z80_ctl_t;

   // i/o port number as seen on a7:a6
   typedef logic [1:0] port_sel_t;

   // kind of bus cycle a test drives
   typedef enum logic [1:0] {
      acc_none    = 2'd0,   // bus idle
      acc_read    = 2'd1,   // memory read
      acc_write   = 2'd2,   // memory write
      acc_refresh = 2'd3    // refresh cycle, ras only
   } access_kind_e;

   // port number carried by an address
   function automatic port_sel_t port_of(input z80_addr_t addr);
      return {addr.a7, addr.a6};
   endfunction

   // true for an i/o write strobe, any port
   function automatic logic io_write(input z80_ctl_t ctl);
      return !ctl.iorq_n && !ctl.wr_n;
   endfunction

endpackage

`default_nettype wire

/* hdl/mioc_map_pkg.sv */
// memory map types
`default_nettype none

package mioc_map_pkg;

   // lower 32k targets, code from bd[1:0]
   typedef enum logic [1:0] {
      low_boot_rom = 2'd0,   // os rom, power-up default
      low_ram_int  = 2'd1,   // on-board dram
      low_ram_exp  = 2'd2,   // expansion dram bank
      low_cart     = 2'd3    // cartridge slot
   } lower_map_e;

   // upper 32k targets, code from bd[3:2]
   typedef enum logic [1:0] {
      up_ram_int = 2'd0,   // on-board dram
      up_ram_exp = 2'd1,   // expansion dram bank
      up_aux_rom = 2'd2,   // slot 2 rom
      up_cart    = 2'd3    // cartridge slot
   } upper_map_e;

   // config register layout, matches bd[3:0]
   typedef struct packed {
      upper_map_e upper_sel;   // bd[3:2]
      lower_map_e lower_sel;   // bd[1:0]
   } map_cfg_t;

   // chip selects, rom side active low, ram side active high
   typedef struct packed {
      logic boot_rom_n;   // boot rom enable
      logic aux_rom_n;    // aux rom enable
      logic cart_n;       // cartridge buffer enable
      logic ram_int;      // internal dram bank hit
      logic ram_exp;      // expansion dram bank hit
   } chip_sel_t;

   // nothing selected
   localparam chip_sel_t SEL_NONE = '{
      boot_rom_n: 1'b1,
      aux_rom_n:  1'b1,
      cart_n:     1'b1,
      ram_int:    1'b0,
      ram_exp:    1'b0
   };

   // every select folded to active high, one bit each
   function automatic logic [4:0] sel_active(input chip_sel_t sel);
      return {~sel.boot_rom_n, ~sel.aux_rom_n, ~sel.cart_n, sel.ram_int, sel.ram_exp};
   endfunction

endpackage

`default_nettype wire

/* hdl/map_config_reg.sv */
// memory map config register
`timescale 1ns/1ns
`default_nettype none

module map_config_reg #(
   parameter mioc_bus_pkg::port_sel_t MAP_PORT  = 2'b01,   // port that takes the map write
   parameter mioc_map_pkg::map_cfg_t  CFG_RESET = '0       // map after reset or reset switch
) (
   input  wire logic                    b_phi,     // z80 clock
   input  wire logic                    arst_n,    // power-on reset
   input  wire logic                    pbrst_n,   // reset switch, sampled
   input  wire mioc_bus_pkg::z80_addr_t addr,      // port number on a7:a6
   input  wire mioc_bus_pkg::z80_ctl_t  ctl,       // iorq_n, wr_n used
   input  wire logic [3:0]              bd,        // data nibble of the write
   output mioc_map_pkg::map_cfg_t       cfg        // current memory map
);

   logic port_wr;   // i/o write hitting our port

   // decode of the port write, no latency
   assign port_wr = mioc_bus_pkg::io_write(ctl)
                    && (mioc_bus_pkg::port_of(addr) == MAP_PORT);

   // reset switch wins over a write in the same cycle
   always_ff @(posedge b_phi or negedge arst_n) begin
      if (!arst_n) begin
         cfg <= CFG_RESET;
      end else if (!pbrst_n) begin
         cfg <= CFG_RESET;                           // switch pressed
      end else if (port_wr) begin
         cfg <= mioc_map_pkg::map_cfg_t'(bd);        // upper in bd[3:2], lower in bd[1:0]
      end
   end

   // the map only moves after a port write or the reset switch
   a_cfg_cause: assert property (
      @(posedge b_phi) disable iff (!arst_n)
      (!$past(port_wr) && $past(pbrst_n)) |-> $stable(cfg)
   ) else $error("map config changed with no port write and no reset switch");

endmodule

`default_nettype wire

/* hdl/memory_decode.sv */
// memory chip select decode
`timescale 1ns/1ns
`default_nettype none

module memory_decode (
   input  wire mioc_bus_pkg::z80_addr_t addr,   // a15 picks the half
   input  wire mioc_bus_pkg::z80_ctl_t  ctl,    // mreq_n and rfsh_n qualify
   input  wire mioc_map_pkg::map_cfg_t  cfg,    // current memory map
   output mioc_map_pkg::chip_sel_t      sel     // one select at most
);

   logic mem_cycle;   // real memory cycle, not refresh

   assign mem_cycle = !ctl.mreq_n && ctl.rfsh_n;   // refresh address is not decoded

   always_comb begin
      sel = mioc_map_pkg::SEL_NONE;   // nothing unless a memory cycle
      if (mem_cycle) begin
         if (!addr.a15) begin
            // lower half, 0000-7fff
            case (cfg.lower_sel)
               mioc_map_pkg::low_boot_rom: begin
                  sel.boot_rom_n = 1'b0;
               end
               mioc_map_pkg::low_ram_int: begin
                  sel.ram_int = 1'b1;
               end
               mioc_map_pkg::low_ram_exp: begin
                  sel.ram_exp = 1'b1;
               end
               mioc_map_pkg::low_cart: begin
                  sel.cart_n = 1'b0;
               end
               default: begin
                  sel = mioc_map_pkg::SEL_NONE;
               end
            endcase
         end else begin
            // upper half, 8000-ffff
            case (cfg.upper_sel)
               mioc_map_pkg::up_ram_int: begin
                  sel.ram_int = 1'b1;
               end
               mioc_map_pkg::up_ram_exp: begin
                  sel.ram_exp = 1'b1;
               end
               mioc_map_pkg::up_aux_rom: begin
                  sel.aux_rom_n = 1'b0;
               end
               mioc_map_pkg::up_cart: begin
                  sel.cart_n = 1'b0;
               end
               default: begin
                  sel = mioc_map_pkg::SEL_NONE;
               end
            endcase
         end
      end
   end

   // selects drive separate chips, two at once would fight on the data bus
   always_comb begin
      a_one_sel: assert ($onehot0(mioc_map_pkg::sel_active(sel)))
         else $error("more than one chip select active: %b",
                     mioc_map_pkg::sel_active(sel));
   end

endmodule

`default_nettype wire

/* hdl/dram_cycle_ctrl.sv */
// dram cycle sequencer
`timescale 1ns/1ns
`default_nettype none

module dram_cycle_ctrl (
   input  wire logic                    b_phi,    // z80 clock
   input  wire logic                    arst_n,   // power-on reset
   input  wire mioc_bus_pkg::z80_addr_t addr,     // a7 row bit, a15 column bit
   input  wire mioc_bus_pkg::z80_ctl_t  ctl,      // mreq_n, rd_n, wr_n, rfsh_n
   input  wire mioc_map_pkg::chip_sel_t sel,      // ram bank hit from decode
   output logic                         ras_n,    // row strobe
   output logic                         mux,      // 0 row address, 1 column address
   output logic                         cas1_n,   // column strobe, internal bank
   output logic                         cas2_n,   // column strobe, expansion bank
   output logic                         ra7       // multiplexed dram address msb
);

   typedef enum logic [2:0] {
      st_idle      = 3'd0,   // waiting for mreq_n
      st_row       = 3'd1,   // address settles, ras next
      st_col       = 3'd2,   // ras low, mux next
      st_hold      = 3'd3,   // cas and hold until mreq_n rises
      st_precharge = 3'd4    // ras high for one cycle
   } dram_state_e;

   dram_state_e state;         // sequencer state
   logic        start;         // begin a dram cycle this edge
   logic        ram_hit;       // decode picked a dram bank
   logic        rw_strobe;     // read or write active
   logic        refresh_q;     // cycle in flight is a refresh
   logic        bank_exp_q;    // cycle in flight targets expansion bank

   assign ram_hit   = sel.ram_int || sel.ram_exp;
   assign rw_strobe = !ctl.rd_n || !ctl.wr_n;
   assign start     = !ctl.mreq_n && (!ctl.rfsh_n || (rw_strobe && ram_hit));

   always_ff @(posedge b_phi or negedge arst_n) begin
      if (!arst_n) begin
         state      <= st_idle;
         ras_n      <= 1'b1;
         mux        <= 1'b0;
         cas1_n     <= 1'b1;
         cas2_n     <= 1'b1;
         refresh_q  <= 1'b0;
         bank_exp_q <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (start) begin
                  state      <= st_row;
                  refresh_q  <= !ctl.rfsh_n;   // ras only refresh
                  bank_exp_q <= sel.ram_exp;   // bank fixed for the whole cycle
               end
            end
            st_row: begin
               state <= st_col;
               ras_n <= 1'b0;                  // start edge + 1
            end
            st_col: begin
               state <= st_hold;
               mux   <= 1'b1;                  // start edge + 2, column address out
            end
            st_hold: begin
               if (ctl.mreq_n) begin
                  state  <= st_precharge;      // bus released, drop everything
                  ras_n  <= 1'b1;
                  mux    <= 1'b0;
                  cas1_n <= 1'b1;
                  cas2_n <= 1'b1;
               end else if (!refresh_q) begin
                  cas1_n <= bank_exp_q;        // start edge + 3, held while in hold
                  cas2_n <= !bank_exp_q;
               end
            end
            st_precharge: begin
               state <= st_idle;
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   // row bit while mux low, column bit while mux high
   assign ra7 = mux ? addr.a15 : addr.a7;

   // column strobe only inside an open row
   a_cas_in_ras: assert property (
      @(posedge b_phi) disable iff (!arst_n)
      (!cas1_n || !cas2_n) |-> (!ras_n && $past(!ras_n))
   ) else $error("cas low without ras held low");

   // one bank at a time
   a_cas_excl: assert property (
      @(posedge b_phi) disable iff (!arst_n)
      !(!cas1_n && !cas2_n)
   ) else $error("cas1_n and cas2_n low together");

endmodule

`default_nettype wire

/* hdl/mioc_top.sv */
// memory and i/o controller
`timescale 1ns/1ns
`default_nettype none

module mioc_top #(
   parameter mioc_bus_pkg::port_sel_t MAP_PORT  = 2'b01,   // map register port on a7:a6
   parameter mioc_map_pkg::map_cfg_t  CFG_RESET = '0       // boot rom low, internal ram high
) (
   input  wire logic       b_phi,         // z80 clock
   input  wire logic       arst_n,        // power-on reset
   input  wire logic       pbrst_n,       // reset switch
   input  wire logic       ba15,          // address 15
   input  wire logic       ba14,          // address 14
   input  wire logic       ba13,          // address 13
   input  wire logic       ba7,           // address 7
   input  wire logic       ba6,           // address 6
   input  wire logic [3:0] bd,            // data bus low nibble
   input  wire logic       bmreq_n,       // buffered memory request
   input  wire logic       iorq_n,        // i/o request
   input  wire logic       brd_n,         // buffered read
   input  wire logic       bwr_n,         // buffered write
   input  wire logic       brfsh_n,       // buffered refresh
   output logic            ras_n,         // dram row strobe
   output logic            mux,           // dram address mux
   output logic            cas1_n,        // dram column strobe, internal
   output logic            cas2_n,        // dram column strobe, expansion
   output logic            ra7,           // dram address msb
   output logic            bootromcs_n,   // boot rom select
   output logic            auxromcs_n,    // aux rom select
   output logic            en245_n        // cartridge buffer enable
);

   mioc_bus_pkg::z80_addr_t addr;   // address pins as one word
   mioc_bus_pkg::z80_ctl_t  ctl;    // strobe pins as one word
   mioc_map_pkg::map_cfg_t  cfg;    // memory map from the port write
   mioc_map_pkg::chip_sel_t sel;    // decoded selects

   assign addr = '{a15: ba15, a14: ba14, a13: ba13, a7: ba7, a6: ba6};
   assign ctl  = '{mreq_n: bmreq_n, iorq_n: iorq_n, rd_n: brd_n, wr_n: bwr_n,
                   rfsh_n: brfsh_n};

   map_config_reg #(
      .MAP_PORT  (MAP_PORT),
      .CFG_RESET (CFG_RESET)
   ) i_map_config_reg (
      .b_phi   (b_phi),
      .arst_n  (arst_n),
      .pbrst_n (pbrst_n),
      .addr    (addr),
      .ctl     (ctl),
      .bd      (bd),
      .cfg     (cfg)
   );

   memory_decode i_memory_decode (
      .addr (addr),
      .ctl  (ctl),
      .cfg  (cfg),
      .sel  (sel)
   );

   dram_cycle_ctrl i_dram_cycle_ctrl (
      .b_phi  (b_phi),
      .arst_n (arst_n),
      .addr   (addr),
      .ctl    (ctl),
      .sel    (sel),
      .ras_n  (ras_n),
      .mux    (mux),
      .cas1_n (cas1_n),
      .cas2_n (cas2_n),
      .ra7    (ra7)
   );

   // rom and cartridge selects go straight to their pins
   assign bootromcs_n = sel.boot_rom_n;
   assign auxromcs_n  = sel.aux_rom_n;
   assign en245_n     = sel.cart_n;   // cartridge data buffer

endmodule

`default_nettype wire

/* include/tb_mioc_table.svh */
// mioc test table
`ifndef TB_MIOC_TABLE_SVH
`define TB_MIOC_TABLE_SVH

// one bus access per row with an optional map register write before it
typedef struct packed {
   logic [127:0]               name;       // 16 characters padded with spaces
   logic                       do_write;   // write the map register first
   logic [1:0]                 wr_port;    // a7:a6 during that write
   logic                       switch_n;   // pbrst_n level during the write
   logic [3:0]                 cfg;        // nibble driven on bd[3:0]
   logic                       a15;        // lower or upper half
   logic                       a7;         // row bit seen on ra7
   mioc_bus_pkg::access_kind_e kind;       // bus cycle to run
   logic [2:0]                 exp_sel;    // bootromcs_n auxromcs_n en245_n
   logic [1:0]                 exp_cas;    // cas1_n and cas2_n once cas is due
   logic [2:0]                 hold;       // base mreq_n low cycles that the lfsr raises by 0 to 3
} test_row_t;

localparam int NUM_TESTS = 17;

localparam test_row_t TEST_TABLE [NUM_TESTS] = '{
   '{"reset_boot      ", 1'b0, 2'b01, 1'b1, 4'h0,   // map straight out of reset
     1'b0, 1'b1, mioc_bus_pkg::acc_read,    3'b011, 2'b11, 3'd4},
   '{"reset_up_int    ", 1'b0, 2'b01, 1'b1, 4'h0,
     1'b1, 1'b0, mioc_bus_pkg::acc_read,    3'b111, 2'b01, 3'd5},
   '{"low_boot        ", 1'b1, 2'b01, 1'b1, 4'h4,   // upper exp and lower boot
     1'b0, 1'b0, mioc_bus_pkg::acc_read,    3'b011, 2'b11, 3'd4},
   '{"up_ram_exp      ", 1'b1, 2'b01, 1'b1, 4'h4,
     1'b1, 1'b1, mioc_bus_pkg::acc_read,    3'b111, 2'b10, 3'd6},
   '{"low_ram_int     ", 1'b1, 2'b01, 1'b1, 4'h9,   // upper aux and lower int
     1'b0, 1'b1, mioc_bus_pkg::acc_write,   3'b111, 2'b01, 3'd4},
   '{"up_aux_rom      ", 1'b1, 2'b01, 1'b1, 4'h9,
     1'b1, 1'b0, mioc_bus_pkg::acc_read,    3'b101, 2'b11, 3'd5},
   '{"low_exp_write   ", 1'b1, 2'b01, 1'b1, 4'he,   // upper cart and lower exp
     1'b0, 1'b0, mioc_bus_pkg::acc_write,   3'b111, 2'b10, 3'd7},
   '{"up_cart         ", 1'b1, 2'b01, 1'b1, 4'he,
     1'b1, 1'b1, mioc_bus_pkg::acc_read,    3'b110, 2'b11, 3'd4},
   '{"low_cart        ", 1'b1, 2'b01, 1'b1, 4'h3,   // upper int and lower cart
     1'b0, 1'b1, mioc_bus_pkg::acc_read,    3'b110, 2'b11, 3'd4},
   '{"up_int_write    ", 1'b1, 2'b01, 1'b1, 4'h3,
     1'b1, 1'b0, mioc_bus_pkg::acc_write,   3'b111, 2'b01, 3'd5},
   '{"refresh_low     ", 1'b1, 2'b01, 1'b1, 4'h6,   // ram in both halves yet no cas
     1'b0, 1'b0, mioc_bus_pkg::acc_refresh, 3'b111, 2'b11, 3'd4},
   '{"refresh_high    ", 1'b1, 2'b01, 1'b1, 4'h8,   // aux rom above must stay deselected
     1'b1, 1'b0, mioc_bus_pkg::acc_refresh, 3'b111, 2'b11, 3'd6},
   '{"idle_bus        ", 1'b1, 2'b01, 1'b1, 4'h9,   // leaves aux high for the next row
     1'b1, 1'b0, mioc_bus_pkg::acc_none,    3'b111, 2'b11, 3'd4},
   '{"other_port      ", 1'b1, 2'b10, 1'b1, 4'h3,   // wrong port so the map stays 4'h9
     1'b1, 1'b0, mioc_bus_pkg::acc_read,    3'b101, 2'b11, 3'd5},
   '{"switch_reset    ", 1'b1, 2'b01, 1'b0, 4'he,   // switch beats the write
     1'b0, 1'b1, mioc_bus_pkg::acc_read,    3'b011, 2'b11, 3'd4},
   '{"switch_up_int   ", 1'b0, 2'b01, 1'b1, 4'h0,
     1'b1, 1'b1, mioc_bus_pkg::acc_read,    3'b111, 2'b01, 3'd4},
   '{"port3_ignored   ", 1'b1, 2'b11, 1'b1, 4'h1,   // port 3 is not the map port
     1'b0, 1'b0, mioc_bus_pkg::acc_read,    3'b011, 2'b11, 3'd5}
};

`endif

/* verification/tb_mioc_top.sv */
// mioc testbench
`timescale 1ns/1ns
`default_nettype none

module tb_mioc_top;

   localparam int          IDLE_TIMEOUT = 16;              // cycles for the strobes to go idle
   localparam logic [31:0] LFSR_SEED    = 32'ha754_d6c7;
   localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1

   `include "tb_mioc_table.svh"

   logic       b_phi;         // z80 clock
   logic       arst_n;        // power-on reset
   logic       pbrst_n;       // reset switch
   logic       ba15;
   logic       ba14;          // don't care, random
   logic       ba13;          // don't care, random
   logic       ba7;
   logic       ba6;
   logic [3:0] bd;            // map nibble
   logic       bmreq_n;
   logic       iorq_n;
   logic       brd_n;
   logic       bwr_n;
   logic       brfsh_n;
   logic       ras_n;
   logic       mux;
   logic       cas1_n;
   logic       cas2_n;
   logic       ra7;
   logic       bootromcs_n;
   logic       auxromcs_n;
   logic       en245_n;

   logic [31:0] lfsr_state;   // shared random source
   int          checks;       // checks run so far
   int          errors;       // checks failed so far

   mioc_top #(
      .MAP_PORT  (2'b01),
      .CFG_RESET ('0)
   ) i_mioc_top (.*);

   always #4 b_phi = ~b_phi;   // 8 ns period

   // one galois step, shift right and fold the taps on a 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ LFSR_TAPS;
      end
      return s >> 1;
   endfunction

   // n bits from the lfsr, one step per bit
   task automatic take_random(input int n, output logic [3:0] val);
      val = 4'h0;
      for (int i = 0; i < n; i++) begin
         val        = {val[2:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // drop the padding from a table name
   function automatic string trim_name(input logic [127:0] raw);
      string      s;
      logic [7:0] ch;
      s = "";
      for (int i = 15; i >= 0; i--) begin
         ch = raw[i*8 +: 8];
         if (ch != 8'h00 && ch != 8'h20) begin
            s = $sformatf("%s%c", s, ch);
         end
      end
      return s;
   endfunction

   task automatic check_pin(input string test, input string pin, input int cycle,
                            input logic exp, input logic act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("Error %s: %s at cycle %0d expected %b, actual %b",
                  test, pin, cycle, exp, act);
      end
   endtask

   // strobes back at rest before the next bus cycle
   task automatic wait_dram_idle(input string test);
      int   n;
      logic idle;
      n    = 0;
      idle = ras_n && cas1_n && cas2_n && !mux;
      while (!idle && n < IDLE_TIMEOUT) begin
         @(negedge b_phi);
         n++;
         idle = ras_n && cas1_n && cas2_n && !mux;
      end
      if (!idle) begin
         errors++;
         $display("Timeout in test %s: the DRAM strobes never returned to idle", test);
         $display("%0d checks, %0d errors", checks, errors);
         $display("Finished with errors");
         $finish;
      end
   endtask

   // single i/o write cycle, optionally with the reset switch held
   task automatic write_map(input test_row_t row);
      @(posedge b_phi);
      #1;
      {ba7, ba6} = row.wr_port;
      bd         = row.cfg;
      pbrst_n    = row.switch_n;
      iorq_n     = 1'b0;
      bwr_n      = 1'b0;
      @(posedge b_phi);           // write edge
      #1;
      iorq_n     = 1'b1;
      bwr_n      = 1'b1;
      pbrst_n    = 1'b1;
   endtask

   // one memory or refresh cycle, every pin checked once per cycle
   task automatic run_access(input test_row_t row);
      string      name;
      logic [3:0] rnd;
      int         hold;       // cycles mreq_n is sampled low
      logic       dram;       // cycle reaches the sequencer
      logic       active;     // mreq_n still low at the sample
      logic       exp_mux;
      logic [2:0] exp_sel;
      logic [1:0] exp_cas;
      name = trim_name(row.name);
      take_random(2, rnd);
      hold = int'(row.hold) + int'(rnd[1:0]);
      take_random(3, rnd);
      dram = (row.kind == mioc_bus_pkg::acc_refresh) || (row.exp_cas != 2'b11);
      wait_dram_idle(name);
      @(posedge b_phi);
      #1;
      ba15              = row.a15;
      ba7               = row.a7;
      {ba14, ba13, ba6} = rnd[2:0];
      bmreq_n           = (row.kind == mioc_bus_pkg::acc_none);
      brd_n             = (row.kind != mioc_bus_pkg::acc_read);
      bwr_n             = (row.kind != mioc_bus_pkg::acc_write);
      brfsh_n           = (row.kind != mioc_bus_pkg::acc_refresh);
      for (int k = 0; k <= hold + 1; k++) begin
         @(posedge b_phi);        // edge 0 is the start edge
         #1;
         if (k == hold - 1) begin
            bmreq_n = 1'b1;       // bus released, sequencer sees it next edge
            brd_n   = 1'b1;
            bwr_n   = 1'b1;
            brfsh_n = 1'b1;
         end
         @(negedge b_phi);        // registered and decoded pins settled
         active  = (row.kind != mioc_bus_pkg::acc_none) && (k <= hold - 2);
         exp_sel = (active && row.kind != mioc_bus_pkg::acc_refresh) ? row.exp_sel : 3'b111;
         exp_mux = dram && (k >= 2) && (k <= hold - 1);
         exp_cas = (dram && k >= 3 && k <= hold - 1) ? row.exp_cas : 2'b11;
         check_pin(name, "ras_n", k, !(dram && k >= 1 && k <= hold - 1), ras_n);
         check_pin(name, "mux", k, exp_mux, mux);
         check_pin(name, "cas1_n", k, exp_cas[1], cas1_n);
         check_pin(name, "cas2_n", k, exp_cas[0], cas2_n);
         check_pin(name, "ra7", k, exp_mux ? row.a15 : row.a7, ra7);   // column bit once mux is up
         check_pin(name, "bootromcs_n", k, exp_sel[2], bootromcs_n);
         check_pin(name, "auxromcs_n", k, exp_sel[1], auxromcs_n);
         check_pin(name, "en245_n", k, exp_sel[0], en245_n);
      end
   endtask

   initial begin
      b_phi      = 1'b0;
      arst_n     = 1'b0;
      pbrst_n    = 1'b1;
      ba15       = 1'b0;
      ba14       = 1'b0;
      ba13       = 1'b0;
      ba7        = 1'b0;
      ba6        = 1'b0;
      bd         = 4'h0;
      bmreq_n    = 1'b1;
      iorq_n     = 1'b1;
      brd_n      = 1'b1;
      bwr_n      = 1'b1;
      brfsh_n    = 1'b1;
      lfsr_state = LFSR_SEED;
      checks     = 0;
      errors     = 0;
      repeat (5) @(posedge b_phi);
      #1;
      arst_n = 1'b1;
      @(negedge b_phi);
      // idle levels out of reset, bus quiet
      check_pin("after_reset", "ras_n", 0, 1'b1, ras_n);
      check_pin("after_reset", "mux", 0, 1'b0, mux);
      check_pin("after_reset", "cas1_n", 0, 1'b1, cas1_n);
      check_pin("after_reset", "cas2_n", 0, 1'b1, cas2_n);
      check_pin("after_reset", "bootromcs_n", 0, 1'b1, bootromcs_n);
      check_pin("after_reset", "auxromcs_n", 0, 1'b1, auxromcs_n);
      check_pin("after_reset", "en245_n", 0, 1'b1, en245_n);
      for (int i = 0; i < NUM_TESTS; i++) begin
         if (TEST_TABLE[i].do_write) begin
            write_map(TEST_TABLE[i]);
         end
         run_access(TEST_TABLE[i]);
      end
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
hdl/mioc_bus_pkg.sv
hdl/mioc_map_pkg.sv
hdl/map_config_reg.sv
hdl/memory_decode.sv
hdl/dram_cycle_ctrl.sv
hdl/mioc_top.sv
verification/tb_mioc_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module tb_mioc_top -f vlog.f \
   -o tb_mioc_top > build.log 2>&1 \
   && ./obj_dir/tb_mioc_top > sim.log 2>&1 \
   || echo "build or simulation stopped early, see build.log and sim.log"

grep -qx "Finished with no errors" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
